//--- common/gpio_pkg.sv
// Pin geometry of the Arduino header on the ATmega328 style core
// Only ports D, B and C are mapped, which gives Arduino pins 0 to 19
// PB7:6 (crystal) and PC6 (reset) are never GPIO on this board

package gpio_pkg;

   ////////////////////////////////////////
   // Port widths and pin numbering
   ////////////////////////////////////////

   localparam int NUM_PINS = 20;     // Arduino D0..D13, A0..A5

   localparam int PORTB_W  = 6;
   localparam int PORTC_W  = 6;
   localparam int PORTD_W  = 8;

   localparam int PORTD_BASE = 0;    // D0..D7
   localparam int PORTB_BASE = 8;    // D8..D13
   localparam int PORTC_BASE = 14;   // A0..A5

   ////////////////////////////////////////
   // One pin word, two readings
   ////////////////////////////////////////

   // Port view, port C in the top bits
   typedef struct packed {
      logic [PORTC_W-1:0] portc;
      logic [PORTB_W-1:0] portb;
      logic [PORTD_W-1:0] portd;
   } arduino_ports_s;

   // Flat view is indexed by Arduino pin number
   typedef union packed {
      logic [NUM_PINS-1:0] pin;
      arduino_ports_s      port;
   } arduino_pins_u;

endpackage

//--- common/altfn_pkg.sv
// Alternate function positions, as in the ATmega328P port tables
// Bit numbers are within the port, not Arduino pin numbers
// Several functions share a bit; the decoder sets the priority

package altfn_pkg;

   ////////////////////////////////////////
   // Port B
   ////////////////////////////////////////

   localparam int PB_SCK  = 5;   // Also the pin 13 LED
   localparam int PB_MISO = 4;
   localparam int PB_MOSI = 3;
   localparam int PB_SS   = 2;
   localparam int PB_OC1B = 2;   // Shares the pin with SS
   localparam int PB_OC1A = 1;
   localparam int PB_ICP1 = 0;
   localparam int PB_OC2A = 3;   // Shares the pin with MOSI

   ////////////////////////////////////////
   // Port D
   ////////////////////////////////////////

   localparam int PD_OC0A = 6;
   localparam int PD_OC0B = 5;
   localparam int PD_OC2B = 3;
   localparam int PD_T1   = 5;   // Counter inputs
   localparam int PD_T0   = 4;
   localparam int PD_INT1 = 3;   // External interrupts
   localparam int PD_INT0 = 2;

   ////////////////////////////////////////
   // Pin-change interrupt map
   ////////////////////////////////////////

   localparam int PCINT_W      = 24;
   localparam int PCINT_B_BASE = 0;    // PCINT0..5, bits 7:6 unused
   localparam int PCINT_C_BASE = 8;    // PCINT8..13, bits 15:14 unused
   localparam int PCINT_D_BASE = 16;   // PCINT16..23

endpackage

//--- altfn/altfn_decoder.sv
// Alternate-function overrides per pin, after ATmega328P tables 14-4..14-11
// Purely combinational; pins without a function get all overrides at 0
// MISO follows the slave SS rule, so ss_b must be the synchronized SS read

`timescale 1ns/1ps

module altfn_decoder
   import gpio_pkg::*;
   import altfn_pkg::*;
(
   // SPI
   input  logic                spe,
   input  logic                spimaster,
   input  logic                scko,
   input  logic                misoo,
   input  logic                mosio,
   input  logic                ss_b,
   input  logic                portb_ddr_miso,   // DDRB4, slave MISO direction
   // Timer compare outputs
   input  logic                oc0a_enable,
   input  logic                oc0a_pin,
   input  logic                oc0b_enable,
   input  logic                oc0b_pin,
   input  logic                oc1a_enable,
   input  logic                oc1a_pin,
   input  logic                oc1b_enable,
   input  logic                oc1b_pin,
   input  logic                oc2a_enable,
   input  logic                oc2a_pin,
   input  logic                oc2b_enable,
   input  logic                oc2b_pin,
   input  logic                int0_enable,
   input  logic                int1_enable,
   // Input enables
   input  logic [PCINT_W-1:0]  pcint_irq,
   input  logic                pcie0,
   input  logic                pcie1,
   input  logic                pcie2,
   input  logic [PORTC_W-1:0]  adcd,
   // Overrides, by Arduino pin
   output arduino_pins_u       fn_ddoe,    // Direction override
   output arduino_pins_u       fn_ddov,    // 1 = output
   output arduino_pins_u       fn_pvoe,    // Output value override
   output arduino_pins_u       fn_pvov,
   output arduino_pins_u       fn_dieoe,   // Input enable override
   output arduino_pins_u       fn_dieov
);

   always_comb begin
      fn_ddoe  = '0;
      fn_ddov  = '0;
      fn_pvoe  = '0;
      fn_pvov  = '0;
      fn_dieoe = '0;
      fn_dieov = '0;

      ////////////////////////////////////////
      // Port B, SPI and timer 1/2
      ////////////////////////////////////////

      // SCK, driven by master, input in slave
      fn_ddoe.port.portb[PB_SCK] = spe & ~spimaster;
      fn_pvoe.port.portb[PB_SCK] = spe & spimaster;
      fn_pvov.port.portb[PB_SCK] = scko;

      // MISO is tri-stated while the slave is deselected
      fn_ddoe.port.portb[PB_MISO] = spe;                            // Master forces input
      fn_ddov.port.portb[PB_MISO] = ~spimaster & portb_ddr_miso & ~ss_b;
      fn_pvoe.port.portb[PB_MISO] = spe & ~spimaster;
      fn_pvov.port.portb[PB_MISO] = misoo;

      // MOSI and OC2A share B3
      fn_ddoe.port.portb[PB_MOSI] = spe & ~spimaster;               // Slave input
      fn_pvoe.port.portb[PB_OC2A] = (spe & spimaster) | oc2a_enable;
      fn_pvov.port.portb[PB_OC2A] = (spe & mosio) | oc2a_pin;

      // SS is an input in slave mode; OC1B only sets the value
      fn_ddoe.port.portb[PB_SS]   = spe & ~spimaster;
      fn_pvoe.port.portb[PB_OC1B] = oc1b_enable;
      fn_pvov.port.portb[PB_OC1B] = oc1b_pin;

      fn_pvoe.port.portb[PB_OC1A] = oc1a_enable;
      fn_pvov.port.portb[PB_OC1A] = oc1a_pin;

      ////////////////////////////////////////
      // Port D, timer 0/2
      ////////////////////////////////////////

      fn_pvoe.port.portd[PD_OC0A] = oc0a_enable;
      fn_pvov.port.portd[PD_OC0A] = oc0a_pin;
      fn_pvoe.port.portd[PD_OC0B] = oc0b_enable;
      fn_pvov.port.portd[PD_OC0B] = oc0b_pin;
      fn_pvoe.port.portd[PD_OC2B] = oc2b_enable;
      fn_pvov.port.portd[PD_OC2B] = oc2b_pin;

      // Input enable kept on when the pin can wake the core
      for (int k = 0; k < PORTB_W; k++) begin
         fn_dieoe.port.portb[k] = pcint_irq[PCINT_B_BASE + k] & pcie0;
         fn_dieov.port.portb[k] = 1'b1;
      end
      for (int k = 0; k < PORTD_W; k++) begin
         fn_dieoe.port.portd[k] = pcint_irq[PCINT_D_BASE + k] & pcie2;
         fn_dieov.port.portd[k] = 1'b1;
      end

      // INT0 pin takes pcie1, as the datasheet table has it
      fn_dieoe.port.portd[PD_INT0] = (pcint_irq[PCINT_D_BASE + PD_INT0] & pcie1) | int0_enable;
      fn_dieoe.port.portd[PD_INT1] = fn_dieoe.port.portd[PD_INT1] | int1_enable;

      ////////////////////////////////////////
      // Port C, pin change and ADC disable
      ////////////////////////////////////////

      // ADCD alone gives override with value 0, so PINC reads 0
      for (int k = 0; k < PORTC_W; k++) begin
         fn_dieov.port.portc[k] = pcint_irq[PCINT_C_BASE + k] & pcie1;
         fn_dieoe.port.portc[k] = fn_dieov.port.portc[k] | adcd[k];
      end
   end

endmodule

//--- pad/pad_cell.sv
// One GPIO pin: priority mux, tri-state driver, input gate, synchronizer
// Priority is accelerator override, then alternate function, then DDR/PORT
// SYNC_STAGES must be 1 to 3; flops clear to 0 on reset

`timescale 1ns/1ps

module pad_cell #(
   parameter int SYNC_STAGES = 2
) (
   input  logic clk,
   input  logic arst_n,
   input  logic ddr,        // DDRx bit
   input  logic port,       // PORTx bit
   input  logic xb_ddoe,
   input  logic xb_ddov,
   input  logic xb_pvoe,
   input  logic xb_pvov,
   input  logic fn_ddoe,
   input  logic fn_ddov,
   input  logic fn_pvoe,
   input  logic fn_pvov,
   input  logic fn_dieoe,
   input  logic fn_dieov,
   input  logic sleep,
   inout  wire  pad,
   output logic pad_raw,    // Ungated, unsynchronized
   output logic pin_sync
);

   logic                   oe;       // Output enable
   logic                   dout;     // Output value
   logic                   ie;       // Input enable
   logic [SYNC_STAGES-1:0] sync_q;

   ////////////////////////////////////////
   // Drive side
   ////////////////////////////////////////

   assign oe   = xb_ddoe ? xb_ddov : (fn_ddoe ? fn_ddov : ddr);
   assign dout = xb_pvoe ? xb_pvov : (fn_pvoe ? fn_pvov : port);

   assign pad     = oe ? dout : 1'bz;   // Released when not an output
   assign pad_raw = pad;

   ////////////////////////////////////////
   // Read side
   ////////////////////////////////////////

   // Sleep turns the buffer off unless a function keeps it on
   assign ie = fn_dieoe ? fn_dieov : ~sleep;

   // Shift in at bit 0, read out of the top bit
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         sync_q <= '0;
      end else begin
         sync_q <= (sync_q << 1) | SYNC_STAGES'(pad & ie);
      end
   end

   assign pin_sync = sync_q[SYNC_STAGES-1];

endmodule

//--- source/pin_distributor.sv
// Routes synchronized pin reads to PINx, peripheral inputs and pin-change bits
// xb_pinx and the LED tap come from the raw pads, so they lead PINx
// Unmapped pin-change bits (7:6, 15:14) read 0

`timescale 1ns/1ps

module pin_distributor
   import gpio_pkg::*;
   import altfn_pkg::*;
(
   input  arduino_pins_u       pin_sync,
   input  arduino_pins_u       pad_raw,
   output logic [PORTB_W-1:0]  portb_pinx,
   output logic [PORTC_W-1:0]  portc_pinx,
   output logic [PORTD_W-1:0]  portd_pinx,
   output arduino_pins_u       xb_pinx,
   output logic [PCINT_W-1:0]  pcint_rcv,
   output logic                scki,
   output logic                misoi,
   output logic                mosii,
   output logic                ss_b,
   output logic                icp1_pin,
   output logic                t0_pin,
   output logic                t1_pin,
   output logic                int0_rcv,
   output logic                int1_rcv,
   output logic                pin13_led
);

   ////////////////////////////////////////
   // Synchronized reads
   ////////////////////////////////////////

   assign portb_pinx = pin_sync.port.portb;
   assign portc_pinx = pin_sync.port.portc;
   assign portd_pinx = pin_sync.port.portd;

   // SPI inputs, both modes
   assign scki  = pin_sync.port.portb[PB_SCK];
   assign misoi = pin_sync.port.portb[PB_MISO];
   assign mosii = pin_sync.port.portb[PB_MOSI];
   assign ss_b  = pin_sync.port.portb[PB_SS];     // Active low select

   assign icp1_pin = pin_sync.port.portb[PB_ICP1];
   assign t0_pin   = pin_sync.port.portd[PD_T0];
   assign t1_pin   = pin_sync.port.portd[PD_T1];
   assign int0_rcv = pin_sync.port.portd[PD_INT0];
   assign int1_rcv = pin_sync.port.portd[PD_INT1];

   // Pin-change map, PCMSK bit order
   always_comb begin
      pcint_rcv = '0;
      pcint_rcv[PCINT_B_BASE +: PORTB_W] = pin_sync.port.portb;
      pcint_rcv[PCINT_C_BASE +: PORTC_W] = pin_sync.port.portc;
      pcint_rcv[PCINT_D_BASE +: PORTD_W] = pin_sync.port.portd;
   end

   ////////////////////////////////////////
   // Raw pad taps
   ////////////////////////////////////////

   assign xb_pinx   = pad_raw;
   assign pin13_led = pad_raw.pin[PORTB_BASE + PB_SCK];   // D13 is SCK

endmodule

//--- source/avr_iomux.sv
// Pin multiplexer for Arduino pins 0..19 (ports D, B and C)
// Pads and xb_pinx are combinational from the controls
// Every synchronized read lags the pad by SYNC_STAGES clocks (1 to 3)
// No pull-up control, no I2C, no UART pins

`timescale 1ns/1ps

module avr_iomux
   import gpio_pkg::*;
   import altfn_pkg::*;
#(
   parameter int SYNC_STAGES = 2
) (
   input  logic                clk,
   input  logic                arst_n,
   input  logic                sleep,         // Input buffers off
   input  logic [PORTC_W-1:0]  adcd,          // Digital input disable, port C
   // Port registers
   input  logic [PORTB_W-1:0]  portb_portx,
   input  logic [PORTB_W-1:0]  portb_ddrx,
   input  logic [PORTC_W-1:0]  portc_portx,
   input  logic [PORTC_W-1:0]  portc_ddrx,
   input  logic [PORTD_W-1:0]  portd_portx,
   input  logic [PORTD_W-1:0]  portd_ddrx,
   output logic [PORTB_W-1:0]  portb_pinx,
   output logic [PORTC_W-1:0]  portc_pinx,
   output logic [PORTD_W-1:0]  portd_pinx,
   // Pads
   inout  wire  [PORTB_W-1:0]  portb_pads,
   inout  wire  [PORTC_W-1:0]  portc_pads,
   inout  wire  [PORTD_W-1:0]  portd_pads,
   // Accelerator block overrides, by Arduino pin
   input  arduino_pins_u       xb_ddoe,
   input  arduino_pins_u       xb_ddov,
   input  arduino_pins_u       xb_pvoe,
   input  arduino_pins_u       xb_pvov,
   output arduino_pins_u       xb_pinx,       // Raw pads, not synchronized
   // Pin change
   input  logic [PCINT_W-1:0]  pcint_irq,     // PCMSK0..2
   input  logic                pcie0,
   input  logic                pcie1,
   input  logic                pcie2,
   output logic [PCINT_W-1:0]  pcint_rcv,
   // SPI
   input  logic                spe,
   input  logic                spimaster,
   input  logic                scko,
   input  logic                misoo,
   input  logic                mosio,
   output logic                scki,
   output logic                misoi,
   output logic                mosii,
   output logic                ss_b,
   // Timer compare outputs
   input  logic                oc0a_enable,
   input  logic                oc0a_pin,
   input  logic                oc0b_enable,
   input  logic                oc0b_pin,
   input  logic                oc1a_enable,
   input  logic                oc1a_pin,
   input  logic                oc1b_enable,
   input  logic                oc1b_pin,
   input  logic                oc2a_enable,
   input  logic                oc2a_pin,
   input  logic                oc2b_enable,
   input  logic                oc2b_pin,
   // Peripheral inputs
   input  logic                int0_enable,
   input  logic                int1_enable,
   output logic                icp1_pin,
   output logic                t0_pin,
   output logic                t1_pin,
   output logic                int0_rcv,
   output logic                int1_rcv,
   output logic                pin13_led
);

   arduino_pins_u ddr_bits;    // DDRx by Arduino pin
   arduino_pins_u port_bits;   // PORTx by Arduino pin
   arduino_pins_u fn_ddoe, fn_ddov, fn_pvoe, fn_pvov, fn_dieoe, fn_dieov;
   arduino_pins_u pin_sync;    // Gated and synchronized reads
   arduino_pins_u pad_raw;

   assign ddr_bits.port.portd  = portd_ddrx;
   assign ddr_bits.port.portb  = portb_ddrx;
   assign ddr_bits.port.portc  = portc_ddrx;
   assign port_bits.port.portd = portd_portx;
   assign port_bits.port.portb = portb_portx;
   assign port_bits.port.portc = portc_portx;

   altfn_decoder u_altfn (.portb_ddr_miso(portb_ddrx[PB_MISO]), .*);

   ////////////////////////////////////////
   // Pad cells, one per Arduino pin
   ////////////////////////////////////////

   for (genvar i = 0; i < NUM_PINS; i++) begin : g_pin
      if (i >= PORTC_BASE) begin : g_c
         pad_cell #(.SYNC_STAGES(SYNC_STAGES)) u_pad (
            .clk, .arst_n, .sleep, .ddr(ddr_bits.pin[i]), .port(port_bits.pin[i]),
            .xb_ddoe(xb_ddoe.pin[i]), .xb_ddov(xb_ddov.pin[i]),
            .xb_pvoe(xb_pvoe.pin[i]), .xb_pvov(xb_pvov.pin[i]),
            .fn_ddoe(fn_ddoe.pin[i]), .fn_ddov(fn_ddov.pin[i]), .fn_pvoe(fn_pvoe.pin[i]),
            .fn_pvov(fn_pvov.pin[i]), .fn_dieoe(fn_dieoe.pin[i]), .fn_dieov(fn_dieov.pin[i]),
            .pad(portc_pads[i - PORTC_BASE]),
            .pad_raw(pad_raw.pin[i]), .pin_sync(pin_sync.pin[i])
         );
      end else if (i >= PORTB_BASE) begin : g_b
         pad_cell #(.SYNC_STAGES(SYNC_STAGES)) u_pad (
            .clk, .arst_n, .sleep, .ddr(ddr_bits.pin[i]), .port(port_bits.pin[i]),
            .xb_ddoe(xb_ddoe.pin[i]), .xb_ddov(xb_ddov.pin[i]),
            .xb_pvoe(xb_pvoe.pin[i]), .xb_pvov(xb_pvov.pin[i]),
            .fn_ddoe(fn_ddoe.pin[i]), .fn_ddov(fn_ddov.pin[i]), .fn_pvoe(fn_pvoe.pin[i]),
            .fn_pvov(fn_pvov.pin[i]), .fn_dieoe(fn_dieoe.pin[i]), .fn_dieov(fn_dieov.pin[i]),
            .pad(portb_pads[i - PORTB_BASE]),
            .pad_raw(pad_raw.pin[i]), .pin_sync(pin_sync.pin[i])
         );
      end else begin : g_d
         pad_cell #(.SYNC_STAGES(SYNC_STAGES)) u_pad (
            .clk, .arst_n, .sleep, .ddr(ddr_bits.pin[i]), .port(port_bits.pin[i]),
            .xb_ddoe(xb_ddoe.pin[i]), .xb_ddov(xb_ddov.pin[i]),
            .xb_pvoe(xb_pvoe.pin[i]), .xb_pvov(xb_pvov.pin[i]),
            .fn_ddoe(fn_ddoe.pin[i]), .fn_ddov(fn_ddov.pin[i]), .fn_pvoe(fn_pvoe.pin[i]),
            .fn_pvov(fn_pvov.pin[i]), .fn_dieoe(fn_dieoe.pin[i]), .fn_dieov(fn_dieov.pin[i]),
            .pad(portd_pads[i - PORTD_BASE]),
            .pad_raw(pad_raw.pin[i]), .pin_sync(pin_sync.pin[i])
         );
      end
   end

   pin_distributor u_dist (.*);   // ss_b also feeds the decoder

endmodule

//--- test/tb_ref_model.svh
// Expected pad drive and pin reads of the pin mux, by Arduino pin number
// Included inside tb_avr_iomux after its stimulus variables are declared
// ss is the DUT's SS level as held in the expected read history

`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// Returns {output enable, output value} for Arduino pin i
function automatic logic [1:0] pad_drive(input int i, input logic ss);
   logic fo, fov;   // Function direction override and value
   logic fv, fvv;   // Function output-value override and value
   logic oe, val;
   fo  = 1'b0;
   fov = 1'b0;
   fv  = 1'b0;
   fvv = 1'b0;
   case (i)
      13: begin                              // B5 is SCK
         fo  = spe & ~spimaster;             // Slave clock is an input
         fv  = spe & spimaster;
         fvv = scko;
      end
      12: begin                              // B4 is MISO
         fo  = spe;
         fov = ~spimaster & ddr_w.pin[12] & ~ss;   // Slave drives only while selected
         fv  = spe & ~spimaster;
         fvv = misoo;
      end
      11: begin                              // B3 carries MOSI or OC2A
         fo  = spe & ~spimaster;
         fv  = (spe & spimaster) | oc2a_enable;
         fvv = (spe & mosio) | oc2a_pin;
      end
      10: begin                              // B2 carries SS or OC1B
         fo  = spe & ~spimaster;
         fv  = oc1b_enable;
         fvv = oc1b_pin;
      end
      9: {fv, fvv} = {oc1a_enable, oc1a_pin};
      6: {fv, fvv} = {oc0a_enable, oc0a_pin};
      5: {fv, fvv} = {oc0b_enable, oc0b_pin};
      3: {fv, fvv} = {oc2b_enable, oc2b_pin};
      default: ;
   endcase
   oe  = xb_ddoe.pin[i] ? xb_ddov.pin[i] : (fo ? fov : ddr_w.pin[i]);
   val = xb_pvoe.pin[i] ? xb_pvov.pin[i] : (fv ? fvv : port_w.pin[i]);
   return {oe, val};
endfunction

// Input enable of Arduino pin i
function automatic logic read_enable(input int i);
   logic ov_en, ov_val;
   ov_val = 1'b1;
   if (i < 8) begin                          // Port D maps to PCINT16..23
      ov_en = pcint_irq[16 + i] & ((i == 2) ? pcie1 : pcie2);
      if (i == 2)
         ov_en = ov_en | int0_enable;
      if (i == 3)
         ov_en = ov_en | int1_enable;
   end else if (i < 14) begin                // Port B maps to PCINT0..5
      ov_en = pcint_irq[i - 8] & pcie0;
   end else begin                            // Port C reads 0 under ADCD alone
      ov_val = pcint_irq[i - 6] & pcie1;
      ov_en  = ov_val | adcd[i - 14];
   end
   return ov_en ? ov_val : ~sleep;
endfunction

// Pad levels with drv on pins the DUT leaves released
function automatic arduino_pins_u pad_levels(input logic ss, input logic [19:0] drv);
   arduino_pins_u r;
   logic [1:0]    d;
   for (int i = 0; i < 20; i++) begin
      d = pad_drive(i, ss);
      r.pin[i] = d[1] ? d[0] : drv[i];
   end
   return r;
endfunction

function automatic arduino_pins_u gate_reads(input arduino_pins_u p);
   arduino_pins_u r;
   for (int i = 0; i < 20; i++)
      r.pin[i] = p.pin[i] & read_enable(i);
   return r;
endfunction

// PCINT0..5 from B, PCINT8..13 from C, PCINT16..23 from D
function automatic logic [23:0] pcint_map(input arduino_pins_u g);
   logic [23:0] r;
   r        = '0;
   r[5:0]   = g.pin[13:8];
   r[13:8]  = g.pin[19:14];
   r[23:16] = g.pin[7:0];
   return r;
endfunction

`endif

//--- test/tb_avr_iomux.sv
// Random testbench for the pin mux with SYNC_STAGES = 2
// Pads are driven by the testbench only where the DUT is expected to release them
// Reads are checked against the gated pad value SYNC_STAGES cycles back

`timescale 1ns/1ps

module tb_avr_iomux
   import gpio_pkg::*;
   import altfn_pkg::*;
();

   localparam int SYNC_STAGES = 2;
   localparam int TEST_LEN    = 200;
   localparam int RESET_LEN   = 4 + SYNC_STAGES + 2;
   localparam int MAX_CYCLES  = RESET_LEN + 4 * TEST_LEN + 2 + 50;

   logic               clk, arst_n, sleep;
   logic [PORTC_W-1:0] adcd;
   arduino_pins_u      ddr_w, port_w;        // DDRx and PORTx by Arduino pin
   arduino_pins_u      xb_ddoe, xb_ddov, xb_pvoe, xb_pvov, xb_pinx;
   logic [PCINT_W-1:0] pcint_irq, pcint_rcv;
   logic               pcie0, pcie1, pcie2;
   logic               spe, spimaster, scko, misoo, mosio, scki, misoi, mosii, ss_b;
   logic               oc0a_enable, oc0a_pin, oc0b_enable, oc0b_pin, oc1a_enable, oc1a_pin;
   logic               oc1b_enable, oc1b_pin, oc2a_enable, oc2a_pin, oc2b_enable, oc2b_pin;
   logic               int0_enable, int1_enable;
   logic               icp1_pin, t0_pin, t1_pin, int0_rcv, int1_rcv, pin13_led;
   logic [PORTB_W-1:0] portb_pinx;
   logic [PORTC_W-1:0] portc_pinx;
   logic [PORTD_W-1:0] portd_pinx;
   logic [19:0]        drv_val, drv_en;      // External drive on the pads
   wire  [19:0]        pads;
   arduino_pins_u      hist [4];             // Expected gated reads with the newest first
   string              test_name;
   int                 errors, checks, cycles;

   `include "tb_ref_model.svh"

   for (genvar i = 0; i < NUM_PINS; i++) begin : g_drv
      assign pads[i] = drv_en[i] ? drv_val[i] : 1'bz;
   end

   avr_iomux #(.SYNC_STAGES(SYNC_STAGES)) uut (
      .portb_ddrx(ddr_w.port.portb), .portb_portx(port_w.port.portb),
      .portc_ddrx(ddr_w.port.portc), .portc_portx(port_w.port.portc),
      .portd_ddrx(ddr_w.port.portd), .portd_portx(port_w.port.portd),
      .portd_pads(pads[7:0]), .portb_pads(pads[13:8]), .portc_pads(pads[19:14]),
      .*
   );

   always #5 clk = ~clk;

   function automatic logic [19:0] rand20();
      return 20'($urandom);
   endfunction

   function automatic logic [19:0] sparse20();   // About one bit in eight
      return rand20() & rand20() & rand20();
   endfunction

   ////////////////////////////////////////
   // Stimulus
   ////////////////////////////////////////

   task automatic apply_stimulus(input int test_id);
      logic [1:0] d;
      sleep     = 1'b0;
      adcd      = '0;
      pcint_irq = '0;
      {pcie0, pcie1, pcie2, int0_enable, int1_enable} = '0;
      {spe, spimaster, scko, misoo, mosio} = '0;
      {oc0a_enable, oc0a_pin, oc0b_enable, oc0b_pin, oc1a_enable, oc1a_pin,
       oc1b_enable, oc1b_pin, oc2a_enable, oc2a_pin, oc2b_enable, oc2b_pin} = '0;
      ddr_w.pin   = rand20();
      port_w.pin  = rand20();
      xb_ddoe.pin = (test_id == 1) ? rand20() : sparse20();   // Dense only in plain GPIO
      xb_ddov.pin = rand20();
      xb_pvoe.pin = (test_id == 1) ? rand20() : sparse20();
      xb_pvov.pin = rand20();
      case (test_id)
         2: begin
            spe = 1'b1;
            {spimaster, scko, misoo, mosio} = 4'($urandom);
         end
         3: {oc0a_enable, oc0a_pin, oc0b_enable, oc0b_pin, oc1a_enable, oc1a_pin,
             oc1b_enable, oc1b_pin, oc2a_enable, oc2a_pin, oc2b_enable, oc2b_pin} = 12'($urandom);
         4: begin
            sleep     = ($urandom % 4) != 0;   // Mostly asleep
            adcd      = 6'($urandom);
            pcint_irq = 24'($urandom);
            {pcie0, pcie1, pcie2, int0_enable, int1_enable} = 5'($urandom);
         end
         default: ;
      endcase
      // Release every pin the DUT should drive this cycle
      for (int i = 0; i < NUM_PINS; i++) begin
         d = pad_drive(i, hist[SYNC_STAGES-1].pin[PORTB_BASE + PB_SS]);
         drv_en[i] = ~d[1];
      end
      drv_val = rand20();
   endtask

   task automatic run_test(input string name, input int test_id, input int len);
      test_name = name;
      repeat (len) begin
         @(posedge clk);
         #1;
         apply_stimulus(test_id);
      end
   endtask

   initial begin
      void'($urandom(32'hcf7f6a80));
      clk    = 1'b0;
      arst_n = 1'b0;
      errors = 0;
      checks = 0;
      cycles = 0;
      for (int k = 0; k < 4; k++)
         hist[k] = '0;
      test_name = "reset";
      apply_stimulus(0);
      run_test("reset", 0, 4);
      arst_n = 1'b1;
      run_test("reset", 0, SYNC_STAGES + 2);   // Reads stay 0 until the flops fill
      run_test("gpio", 1, TEST_LEN);
      run_test("spi", 2, TEST_LEN);
      run_test("timer", 3, TEST_LEN);
      run_test("gating", 4, TEST_LEN);
      repeat (2) @(posedge clk);
      #8;
      $display("Summary: %0d checks, %0d errors", checks, errors);
      if (errors == 0)
         $display("TEST PASS");
      else
         $display("TEST FAIL");
      $finish;
   end

   ////////////////////////////////////////
   // Compare and timeout
   ////////////////////////////////////////

   task automatic compare_val(input string what, input logic [23:0] exp, input logic [23:0] act);
      checks++;
      if (act !== exp) begin
         errors++;
         $display("Mismatch %s %s: expected %h, actual %h", test_name, what, exp, act);
      end
   endtask

   task automatic check_cycle();
      arduino_pins_u exp_rd, exp_pad;
      exp_rd  = hist[SYNC_STAGES-1];
      exp_pad = pad_levels(exp_rd.pin[PORTB_BASE + PB_SS], drv_val);
      compare_val("pads", exp_pad.pin, pads);          // X here means both sides drive
      compare_val("xb_pinx", exp_pad.pin, xb_pinx.pin);
      compare_val("pin13_led", exp_pad.pin[13], pin13_led);
      compare_val("portb_pinx", exp_rd.pin[13:8], portb_pinx);
      compare_val("portc_pinx", exp_rd.pin[19:14], portc_pinx);
      compare_val("portd_pinx", exp_rd.pin[7:0], portd_pinx);
      compare_val("pcint_rcv", pcint_map(exp_rd), pcint_rcv);
      compare_val("spi inputs", exp_rd.pin[13:10], {scki, misoi, mosii, ss_b});
      compare_val("timer inputs", {exp_rd.pin[8], exp_rd.pin[4], exp_rd.pin[5]},
                  {icp1_pin, t0_pin, t1_pin});
      compare_val("int inputs", {exp_rd.pin[2], exp_rd.pin[3]}, {int0_rcv, int1_rcv});
      for (int k = 3; k > 0; k--)
         hist[k] = hist[k-1];
      hist[0] = arst_n ? gate_reads(exp_pad) : '0;   // Flops held clear in reset
   endtask

   always @(posedge clk) begin
      #5;   // Mid-cycle with inputs settled
      check_cycle();
   end

   always @(posedge clk) begin
      cycles++;
      if (cycles >= MAX_CYCLES) begin
         $display("Run did not finish within %0d cycles", MAX_CYCLES);
         $display("Summary: %0d checks, %0d errors", checks, errors);
         $display("TEST FAIL");
         $finish;
      end
   end

endmodule

//--- avr_iomux.f
+incdir+test
common/gpio_pkg.sv
common/altfn_pkg.sv
altfn/altfn_decoder.sv
pad/pad_cell.sv
source/pin_distributor.sv
source/avr_iomux.sv
test/tb_avr_iomux.sv
